//--- source/fetch_pkg.sv
/*
 * Shared types and constants for the instruction-fetch front end.
 * Holds the fetch word and address types, the cache error tags, the
 * exception kinds, the bundled port structs and the reset defaults.
 * Modules refer to its members by scoped name.
 */

package fetch_pkg;

	//////////////////////////////////////////////////
	// Basic words
	//////////////////////////////////////////////////

	// One instruction word
	typedef logic [31:0] insn_t;

	// One byte address
	typedef logic [31:0] addr_t;

	// Error tag returned with a cache response
	typedef enum logic [3:0] {
		ITAG_NONE = 4'h0,
		ITAG_BE   = 4'hb,	// bus error
		ITAG_PE   = 4'hc,	// page fault
		ITAG_TE   = 4'hd	// TLB miss
	} itag_e;

	// Exception kind, also the vector register select
	typedef enum logic [1:0] {
		EXC_NONE   = 2'd0,
		EXC_BUSERR = 2'd1,
		EXC_IMMU   = 2'd2,
		EXC_ITLB   = 2'd3
	} except_e;

	//////////////////////////////////////////////////
	// Port bundles
	//////////////////////////////////////////////////

	// Cache response, ack or err pulses for one cycle
	typedef struct packed {
		insn_t dat;
		addr_t adr;
		logic  ack;
		logic  err;
		itag_e tag;
	} icpu_rsp_t;

	// Stage output toward decode
	typedef struct packed {
		insn_t insn;
		addr_t pc;
		logic  itlbmiss;
		logic  immufault;
		logic  ibuserr;
	} if_out_t;

	// Branch redirect from the core
	typedef struct packed {
		logic  taken;
		addr_t target;
	} redirect_t;

	// Vector register write
	typedef struct packed {
		logic    we;
		except_e sel;
		addr_t   data;
	} cfg_wr_t;

	//////////////////////////////////////////////////
	// Constants
	//////////////////////////////////////////////////

	localparam logic [5:0] NOP_OPCODE = 6'b000101;

	// Killed or bypassed slot
	localparam insn_t NOP_KILL  = {NOP_OPCODE, 26'h0410000};
	// Nothing fetched yet
	localparam insn_t NOP_EMPTY = {NOP_OPCODE, 26'h0610000};

	localparam addr_t RESET_PC       = 32'h0000_0100;
	localparam addr_t VEC_BUSERR_DEF = 32'h0000_0200;
	localparam addr_t VEC_IMMU_DEF   = 32'h0000_0400;
	localparam addr_t VEC_ITLB_DEF   = 32'h0000_0A00;

endpackage

//--- source/fetch_vector_regs.sv
/*
 * Exception vector registers for the fetch front end.
 * Three addresses, written one at a time through the cfg strobe and
 * read combinationally by exception kind to steer the PC generator.
 */

`timescale 1ns/1ps

module fetch_vector_regs (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  fetch_pkg::cfg_wr_t   cfg_i,
	input  fetch_pkg::except_e   kind_i,
	output fetch_pkg::addr_t     vec_o
);

	// One register per real exception kind
	fetch_pkg::addr_t vec_buserr_q;
	fetch_pkg::addr_t vec_immu_q;
	fetch_pkg::addr_t vec_itlb_q;

	//////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////

	// Takes effect on the next edge
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			vec_buserr_q <= fetch_pkg::VEC_BUSERR_DEF;
			vec_immu_q   <= fetch_pkg::VEC_IMMU_DEF;
			vec_itlb_q   <= fetch_pkg::VEC_ITLB_DEF;
		end else if (cfg_i.we) begin
			case (cfg_i.sel)
				fetch_pkg::EXC_BUSERR: vec_buserr_q <= cfg_i.data;
				fetch_pkg::EXC_IMMU:   vec_immu_q   <= cfg_i.data;
				fetch_pkg::EXC_ITLB:   vec_itlb_q   <= cfg_i.data;
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Read port
	//////////////////////////////////////////////////

	// No exception points back at the boot address
	always_comb begin
		case (kind_i)
			fetch_pkg::EXC_BUSERR: vec_o = vec_buserr_q;
			fetch_pkg::EXC_IMMU:   vec_o = vec_immu_q;
			fetch_pkg::EXC_ITLB:   vec_o = vec_itlb_q;
			default:               vec_o = fetch_pkg::RESET_PC;
		endcase
	end

	// Core must never address the empty slot
	assert property (@(posedge clk) disable iff (!rst_n_i)
		cfg_i.we |-> (cfg_i.sel != fetch_pkg::EXC_NONE));

endmodule

//--- source/fetch_pcgen.sv
/*
 * Fetch program counter for the instruction-cache port.
 * Steps by one word after each accepted response, loads a redirect
 * target on a flush, jumps to a vector on a fetch exception and holds
 * under freeze or while the cache has not answered.
 */

`timescale 1ns/1ps

module fetch_pcgen (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic                   freeze_i,
	input  logic                   flush_i,
	input  fetch_pkg::redirect_t   redirect_i,
	input  logic                   stall_i,
	input  fetch_pkg::except_e     exc_kind_i,
	input  fetch_pkg::addr_t       vec_i,
	output fetch_pkg::addr_t       adr_o
);

	fetch_pkg::addr_t pc_q;
	fetch_pkg::addr_t pc_next;

	// Redirect and vector paths
	logic do_redirect;
	logic do_vector;

	//////////////////////////////////////////////////
	// Next-PC select
	//////////////////////////////////////////////////

	assign do_redirect = flush_i & redirect_i.taken;

	// A frozen pipe keeps its PC, a saved fault vectors once it thaws
	assign do_vector = (exc_kind_i != fetch_pkg::EXC_NONE) & ~freeze_i;

	always_comb begin
		pc_next = pc_q;
		if (do_redirect) begin
			// Highest priority
			pc_next = redirect_i.target;
		end else if (do_vector) begin
			pc_next = vec_i;
		end else if (freeze_i || stall_i) begin
			// Back-pressure, hold the address on the bus
			pc_next = pc_q;
		end else begin
			// Sequential word
			pc_next = pc_q + 32'd4;
		end
	end

	//////////////////////////////////////////////////
	// PC register
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pc_q <= fetch_pkg::RESET_PC;
		end else begin
			pc_q <= pc_next;
		end
	end

	// Drives the cache directly
	assign adr_o = pc_q;

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// Targets and vectors must keep fetches word sized
	assert property (@(posedge clk) disable iff (!rst_n_i)
		adr_o[1:0] == 2'b00);

	// Freeze holds the cache address unless the pipe is flushed
	assert property (@(posedge clk) disable iff (!rst_n_i)
		(freeze_i && !flush_i) |=> $stable(adr_o));

endmodule

//--- source/fetch_insn_reg.sv
/*
 * IF-stage instruction register.
 * Passes each cache response to decode, saves it while the pipe is
 * frozen, swaps in a NOP for killed or bypassed slots and turns the
 * cache error tag into the three fetch exception flags.
 */

`timescale 1ns/1ps

module fetch_insn_reg (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  fetch_pkg::icpu_rsp_t   rsp_i,
	input  logic                   freeze_i,
	input  logic                   flush_i,
	input  logic                   no_more_dslot_i,
	input  logic                   rfe_i,
	output fetch_pkg::if_out_t     if_o,
	output logic                   stall_o,
	output logic                   saving_o,
	output logic                   refetch_o,
	output fetch_pkg::except_e     exc_kind_o
);

	// Control state
	logic saved;
	logic bypass_q;

	// Saved payload, only read while saved is set
	fetch_pkg::insn_t insn_saved;
	fetch_pkg::addr_t addr_saved;
	logic [2:0]       err_saved;	// {buserr, immu, itlb}

	logic       save_insn;
	logic       bypass;
	logic [2:0] err_live;
	logic [2:0] err_show;

	//////////////////////////////////////////////////
	// Response decode
	//////////////////////////////////////////////////

	// Tag matters only alongside err
	assign err_live[0] = rsp_i.err & (rsp_i.tag == fetch_pkg::ITAG_TE);
	assign err_live[1] = rsp_i.err & (rsp_i.tag == fetch_pkg::ITAG_PE);
	assign err_live[2] = rsp_i.err & (rsp_i.tag == fetch_pkg::ITAG_BE);

	// Response landing in a frozen stage with a free slot
	assign save_insn = (rsp_i.ack | rsp_i.err) & freeze_i & ~saved;
	assign saving_o  = save_insn & ~flush_i;

	// Flush cycle plus the one after
	assign bypass = flush_i | bypass_q;

	//////////////////////////////////////////////////
	// Control registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			bypass_q <= 1'b0;
		end else begin
			bypass_q <= flush_i;
		end
	end

	// Set on a save, cleared by flush or thaw
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			saved <= 1'b0;
		end else if (flush_i) begin
			saved <= 1'b0;
		end else if (save_insn) begin
			saved <= 1'b1;
		end else if (!freeze_i) begin
			saved <= 1'b0;
		end
	end

	// Capture the response that arrived during freeze
	always_ff @(posedge clk) begin
		if (save_insn) begin
			insn_saved <= rsp_i.err ? fetch_pkg::NOP_KILL : rsp_i.dat;
			addr_saved <= {rsp_i.adr[31:2], 2'b00};
			err_saved  <= err_live;
		end
	end

	//////////////////////////////////////////////////
	// Stage output
	//////////////////////////////////////////////////

	always_comb begin
		if (no_more_dslot_i || rfe_i || bypass) begin
			if_o.insn = fetch_pkg::NOP_KILL;
		end else if (saved) begin
			if_o.insn = insn_saved;
		end else if (rsp_i.ack) begin
			if_o.insn = rsp_i.dat;
		end else begin
			// Error or nothing yet
			if_o.insn = fetch_pkg::NOP_EMPTY;
		end
	end

	assign if_o.pc = saved ? addr_saved : {rsp_i.adr[31:2], 2'b00};

	// Delay-slot end masks every fault
	assign err_show = no_more_dslot_i ? 3'b000 : (saved ? err_saved : err_live);

	assign if_o.itlbmiss  = err_show[0];
	assign if_o.immufault = err_show[1];
	assign if_o.ibuserr   = err_show[2];

	// Exception kind seen by the PC generator
	always_comb begin
		if (err_show[0]) begin
			exc_kind_o = fetch_pkg::EXC_ITLB;
		end else if (err_show[1]) begin
			exc_kind_o = fetch_pkg::EXC_IMMU;
		end else if (err_show[2]) begin
			exc_kind_o = fetch_pkg::EXC_BUSERR;
		end else begin
			exc_kind_o = fetch_pkg::EXC_NONE;
		end
	end

	assign stall_o   = ~rsp_i.err & ~rsp_i.ack & ~saved;
	assign refetch_o = saved & rsp_i.ack;

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	assert property (@(posedge clk) disable iff (!rst_n_i)
		no_more_dslot_i |-> !(if_o.itlbmiss || if_o.immufault || if_o.ibuserr));

	// Unflushed save always lands
	assert property (@(posedge clk) disable iff (!rst_n_i)
		(save_insn && !flush_i) |=> saved);

	assert property (@(posedge clk) disable iff (!rst_n_i)
		flush_i |=> !saved);

endmodule

//--- source/fetch_top.sv
/*
 * Instruction-fetch front end top level.
 * Connects the PC generator, the IF-stage instruction register and the
 * exception vector registers between the cache port and the core.
 */

`timescale 1ns/1ps

module fetch_top (
	input  logic                   clk,
	input  logic                   rst_n_i,
	// Cache port
	input  fetch_pkg::icpu_rsp_t   icpu_rsp_i,
	output fetch_pkg::addr_t       icpu_adr_o,
	// Pipeline control
	input  logic                   freeze_i,
	input  logic                   flush_i,
	input  fetch_pkg::redirect_t   redirect_i,
	input  logic                   no_more_dslot_i,
	input  logic                   rfe_i,
	input  fetch_pkg::cfg_wr_t     cfg_i,
	// Toward decode
	output fetch_pkg::if_out_t     if_o,
	output logic                   stall_o,
	output logic                   saving_o,
	output logic                   refetch_o
);

	// Exception kind steers the vector read
	fetch_pkg::except_e exc_kind;
	fetch_pkg::addr_t   vec_addr;

	//////////////////////////////////////////////////
	// Blocks
	//////////////////////////////////////////////////

	fetch_insn_reg u_insn_reg (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.rsp_i           (icpu_rsp_i),
		.freeze_i        (freeze_i),
		.flush_i         (flush_i),
		.no_more_dslot_i (no_more_dslot_i),
		.rfe_i           (rfe_i),
		.if_o            (if_o),
		.stall_o         (stall_o),
		.saving_o        (saving_o),
		.refetch_o       (refetch_o),
		.exc_kind_o      (exc_kind)
	);

	fetch_vector_regs u_vector_regs (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.cfg_i   (cfg_i),
		.kind_i  (exc_kind),
		.vec_o   (vec_addr)
	);

	// Stall from the instruction register is the back-pressure
	fetch_pcgen u_pcgen (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.freeze_i   (freeze_i),
		.flush_i    (flush_i),
		.redirect_i (redirect_i),
		.stall_i    (stall_o),
		.exc_kind_i (exc_kind),
		.vec_i      (vec_addr),
		.adr_o      (icpu_adr_o)
	);

endmodule

//--- verif/fetch_tb_clk.sv
/*
 * Clock and reset source for the fetch testbench.
 * 20 ns clock, reset held low over the first two rising edges.
 */

`timescale 1ns/1ps

module fetch_tb_clk (
	output logic clk,
	output logic rst_n_o
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Release lines up with the 2 ns input drive point
	initial begin
		rst_n_o = 1'b0;
		repeat (2) @(posedge clk);
		#2;
		rst_n_o = 1'b1;
	end

endmodule

//--- verif/fetch_tb.sv
/*
 * Directed testbench for the instruction-fetch front end.
 * Plays the instruction cache from a random word table, drives inputs
 * 2 ns after each rising edge and checks outputs 10 ns later.
 * Prints one line per test and a closing summary.
 */

`timescale 1ns/1ps

module fetch_tb;

	localparam int WAIT_LIMIT = 10;

	logic clk;
	logic rst_n;
	fetch_pkg::icpu_rsp_t icpu_rsp;
	fetch_pkg::addr_t     icpu_adr;
	fetch_pkg::redirect_t redirect;
	fetch_pkg::cfg_wr_t   cfg;
	fetch_pkg::if_out_t   if_out;
	logic freeze;
	logic flush;
	logic no_more_dslot;
	logic rfe;
	logic stall;
	logic saving;
	logic refetch;

	// Cache contents, indexed by address bits 9:2
	fetch_pkg::insn_t insn_tbl [0:255];
	integer seed;
	int errors;
	int tests_ok;
	int tests_bad;
	fetch_pkg::addr_t exp_pc;

	fetch_tb_clk clk_gen (.clk(clk), .rst_n_o(rst_n));

	fetch_top dut0 (
		.clk(clk), .rst_n_i(rst_n), .icpu_rsp_i(icpu_rsp), .icpu_adr_o(icpu_adr),
		.freeze_i(freeze), .flush_i(flush), .redirect_i(redirect),
		.no_more_dslot_i(no_more_dslot), .rfe_i(rfe), .cfg_i(cfg), .if_o(if_out),
		.stall_o(stall), .saving_o(saving), .refetch_o(refetch)
	);

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////

	task automatic check_if(input string what, input fetch_pkg::if_out_t got,
			input fetch_pkg::if_out_t exp);
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t: %s got insn=%h pc=%h flags=%b expected insn=%h pc=%h flags=%b",
				$time, what, got.insn, got.pc, {got.itlbmiss, got.immufault, got.ibuserr},
				exp.insn, exp.pc, {exp.itlbmiss, exp.immufault, exp.ibuserr});
		end
	endtask

	task automatic check_addr(input string what, input fetch_pkg::addr_t got,
			input fetch_pkg::addr_t exp);
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input string what, input bit got, input bit exp);
		if (got !== exp) begin
			errors++;
			$display("FAIL t=%0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////

	// Flags ordered {itlbmiss, immufault, ibuserr}
	function automatic fetch_pkg::if_out_t make_if(input fetch_pkg::insn_t insn,
			input fetch_pkg::addr_t pc, input logic [2:0] flags);
		fetch_pkg::if_out_t r;
		r.insn      = insn;
		r.pc        = pc;
		r.itlbmiss  = flags[2];
		r.immufault = flags[1];
		r.ibuserr   = flags[0];
		return r;
	endfunction

	// Cache model, word taken from the table for the given address
	task automatic respond(input logic ack, input logic err, input fetch_pkg::itag_e tag,
			input fetch_pkg::addr_t adr);
		icpu_rsp.dat = insn_tbl[adr[9:2]];
		icpu_rsp.adr = adr;
		icpu_rsp.ack = ack;
		icpu_rsp.err = err;
		icpu_rsp.tag = tag;
	endtask

	// Drive point of a new cycle, the PC has settled by now
	task automatic begin_cycle(input string what, input fetch_pkg::addr_t exp_adr);
		@(posedge clk);
		#2;
		// Cache pulses last one cycle
		respond(1'b0, 1'b0, fetch_pkg::ITAG_NONE, '0);
		check_addr(what, icpu_adr, exp_adr);
	endtask

	task automatic report_timeout(input string what);
		errors++;
		$display("Timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
	endtask

	// Bring the stage back to waiting on the cache
	task automatic wait_idle();
		int n;
		n = 0;
		do begin
			@(posedge clk);
			#2;
			respond(1'b0, 1'b0, fetch_pkg::ITAG_NONE, '0);
			{freeze, flush, no_more_dslot, rfe} = 4'b0000;
			redirect = '0;
			cfg      = '0;
			#8;
			n++;
		end while (stall !== 1'b1 && n < WAIT_LIMIT);
		if (stall !== 1'b1) begin
			report_timeout("return of the fetch stage to idle");
		end
	endtask

	task automatic end_test(input string name, input int err0);
		if (errors == err0) begin
			tests_ok++;
			$display("%s: ok", name);
		end else begin
			tests_bad++;
			$display("%s: %0d mismatches", name, errors - err0);
		end
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic test_reset();
		int err0;
		err0   = errors;
		exp_pc = fetch_pkg::RESET_PC;
		begin_cycle("reset address", exp_pc);
		#8;
		check_flag("reset stall", stall, 1'b1);
		check_flag("reset saving", saving, 1'b0);
		check_flag("reset refetch", refetch, 1'b0);
		check_if("reset output", if_out, make_if(fetch_pkg::NOP_EMPTY, '0, 3'b000));
		end_test("reset", err0);
	endtask

	task automatic test_sequential();
		int err0;
		err0 = errors;
		wait_idle();
		for (int i = 0; i < 10; i++) begin
			begin_cycle("sequential address", exp_pc);
			respond(1'b1, 1'b0, fetch_pkg::ITAG_NONE, exp_pc);
			#8;
			check_flag("sequential stall", stall, 1'b0);
			check_if("sequential output", if_out, make_if(insn_tbl[exp_pc[9:2]], exp_pc, 3'b000));
			exp_pc = exp_pc + 32'd4;
		end
		begin_cycle("address after last ack", exp_pc);
		end_test("sequential fetch", err0);
	endtask

	task automatic test_freeze_save();
		int err0;
		fetch_pkg::addr_t a0;
		fetch_pkg::insn_t w0;
		err0 = errors;
		wait_idle();
		a0 = exp_pc;
		w0 = insn_tbl[a0[9:2]];
		// Ack lands in a frozen stage
		begin_cycle("address before freeze", a0);
		freeze = 1'b1;
		respond(1'b1, 1'b0, fetch_pkg::ITAG_NONE, a0);
		#8;
		check_flag("saving on frozen ack", saving, 1'b1);
		check_if("frozen ack output", if_out, make_if(w0, a0, 3'b000));
		// Response changes, saved word stays
		begin_cycle("address held in freeze", a0);
		respond(1'b1, 1'b0, fetch_pkg::ITAG_NONE, a0 + 32'd4);
		#8;
		check_if("saved output", if_out, make_if(w0, a0, 3'b000));
		check_flag("refetch with next ack", refetch, 1'b1);
		check_flag("no second save", saving, 1'b0);
		begin_cycle("address held in freeze", a0);
		respond(1'b0, 1'b0, fetch_pkg::ITAG_NONE, '0);
		#8;
		check_if("saved output while quiet", if_out, make_if(w0, a0, 3'b000));
		check_flag("refetch without ack", refetch, 1'b0);
		check_flag("stall while saved", stall, 1'b0);
		// Thaw hands over the saved word and the PC moves on
		begin_cycle("address held in freeze", a0);
		freeze = 1'b0;
		#8;
		check_if("thaw output", if_out, make_if(w0, a0, 3'b000));
		exp_pc = a0 + 32'd4;
		begin_cycle("address after thaw", exp_pc);
		respond(1'b1, 1'b0, fetch_pkg::ITAG_NONE, exp_pc);
		#8;
		check_if("live output after thaw", if_out,
			make_if(insn_tbl[exp_pc[9:2]], exp_pc, 3'b000));
		check_flag("refetch after thaw", refetch, 1'b0);
		exp_pc = exp_pc + 32'd4;
		begin_cycle("address after live ack", exp_pc);
		end_test("freeze save", err0);
	endtask

	task automatic test_error_tags();
		int err0;
		fetch_pkg::itag_e tags [3];
		fetch_pkg::addr_t vecs [3];
		logic [2:0]       flags [3];
		err0 = errors;
		// Bus error, page fault, TLB miss
		tags[0]  = fetch_pkg::ITAG_BE;
		tags[1]  = fetch_pkg::ITAG_PE;
		tags[2]  = fetch_pkg::ITAG_TE;
		vecs[0]  = fetch_pkg::VEC_BUSERR_DEF;
		vecs[1]  = fetch_pkg::VEC_IMMU_DEF;
		vecs[2]  = fetch_pkg::VEC_ITLB_DEF;
		flags[0] = 3'b001;
		flags[1] = 3'b010;
		flags[2] = 3'b100;
		for (int k = 0; k < 3; k++) begin
			wait_idle();
			begin_cycle("address before error", exp_pc);
			respond(1'b0, 1'b1, tags[k], exp_pc);
			#8;
			check_if("error output", if_out, make_if(fetch_pkg::NOP_EMPTY, exp_pc, flags[k]));
			check_flag("stall on error", stall, 1'b0);
			exp_pc = vecs[k];
			begin_cycle("exception vector", exp_pc);
			// Same fault at the end of a delay slot is masked
			no_more_dslot = 1'b1;
			respond(1'b0, 1'b1, tags[k], exp_pc);
			#8;
			check_if("masked error output", if_out, make_if(fetch_pkg::NOP_KILL, exp_pc, 3'b000));
			exp_pc = exp_pc + 32'd4;
			begin_cycle("address after masked error", exp_pc);
		end
		end_test("error tags", err0);
	endtask

	task automatic test_flush_redirect();
		int err0;
		fetch_pkg::addr_t target;
		err0   = errors;
		target = 32'h0000_0340;
		wait_idle();
		begin_cycle("address before flush", exp_pc);
		flush           = 1'b1;
		redirect.taken  = 1'b1;
		redirect.target = target;
		respond(1'b1, 1'b0, fetch_pkg::ITAG_NONE, exp_pc);
		#8;
		check_if("flush cycle output", if_out, make_if(fetch_pkg::NOP_KILL, exp_pc, 3'b000));
		begin_cycle("redirect target", target);
		flush    = 1'b0;
		redirect = '0;
		respond(1'b1, 1'b0, fetch_pkg::ITAG_NONE, target);
		#8;
		check_if("cycle after flush", if_out, make_if(fetch_pkg::NOP_KILL, target, 3'b000));
		exp_pc = target + 32'd4;
		begin_cycle("address after target", exp_pc);
		respond(1'b1, 1'b0, fetch_pkg::ITAG_NONE, exp_pc);
		#8;
		check_if("first live word after flush", if_out,
			make_if(insn_tbl[exp_pc[9:2]], exp_pc, 3'b000));
		exp_pc = exp_pc + 32'd4;
		begin_cycle("address after live word", exp_pc);
		end_test("flush and redirect", err0);
	endtask

	task automatic test_vector_config();
		int err0;
		fetch_pkg::addr_t new_vec;
		err0    = errors;
		new_vec = 32'h0000_0C80;
		wait_idle();
		begin_cycle("address before vector write", exp_pc);
		cfg.we   = 1'b1;
		cfg.sel  = fetch_pkg::EXC_ITLB;
		cfg.data = new_vec;
		#8;
		begin_cycle("address held while idle", exp_pc);
		cfg = '0;
		respond(1'b0, 1'b1, fetch_pkg::ITAG_TE, exp_pc);
		#8;
		check_if("TLB miss output", if_out, make_if(fetch_pkg::NOP_EMPTY, exp_pc, 3'b100));
		exp_pc = new_vec;
		begin_cycle("written ITLB vector", exp_pc);
		end_test("vector configuration", err0);
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin : main_seq
		int n;
		seed      = 32'hab2cbba8;
		errors    = 0;
		tests_ok  = 0;
		tests_bad = 0;
		{freeze, flush, no_more_dslot, rfe} = 4'b0000;
		redirect = '0;
		cfg      = '0;
		icpu_rsp = '0;
		for (int i = 0; i < 256; i++) begin
			insn_tbl[i] = $random(seed);
		end
		n = 0;
		while (rst_n !== 1'b1 && n < WAIT_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (rst_n !== 1'b1) begin
			report_timeout("reset release");
		end
		test_reset();
		test_sequential();
		test_freeze_save();
		test_error_tags();
		test_flush_redirect();
		test_vector_config();
		$display("Summary: %0d tests clean, %0d tests with mismatches, %0d mismatches in all",
			tests_ok, tests_bad, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- flist.f
source/fetch_pkg.sv
source/fetch_vector_regs.sv
source/fetch_pcgen.sv
source/fetch_insn_reg.sv
source/fetch_top.sv
verif/fetch_tb_clk.sv
verif/fetch_tb.sv
